//--- common/core_config.svh
//********************
// core width and register file sizing
// include wherever the macros are needed
//********************
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// data path width, fixed by RV32I
`define CORE_XLEN 32

// architectural integer registers, x0 included
`define CORE_NUM_REGS 32

// bits needed to name one register
`define CORE_REG_IDX_W 5

`endif

//--- common/isa_pkg.sv
//********************
// RV32I encodings and basic word types
// used by every RTL file through isa_pkg:: names
//********************
`default_nettype none

`include "core_config.svh"

package isa_pkg;

    // one data word
    typedef logic [`CORE_XLEN-1:0] word_t;

    // register index
    typedef logic [`CORE_REG_IDX_W-1:0] reg_idx_t;

    // shift amount, low bits of operand b
    typedef logic [$clog2(`CORE_XLEN)-1:0] shamt_t;

    // major opcodes that the core accepts
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111
    } opcode_e;

    // funct3 field, shared by OP and OP_IMM
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_e;

    // funct7 field, alt selects sub and sra
    typedef enum logic [6:0] {
        F7_BASE = 7'b0000000,
        F7_ALT  = 7'b0100000
    } funct7_e;

    // operations the alu can run
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        // lui result is the immediate
        ALU_PASS_B
    } alu_op_e;

endpackage

`default_nettype wire

//--- common/pipe_pkg.sv
//********************
// records carried between the pipeline stages
// decode fills id_ex_t, execute fills wb_t
//********************
`default_nettype none

package pipe_pkg;

    // ID/EX record, built by decode
    typedef struct packed {
        // slot holds a real instruction
        logic              valid;
        // destination register
        isa_pkg::reg_idx_t rd;
        // source indices, kept for forwarding
        isa_pkg::reg_idx_t rs1;
        isa_pkg::reg_idx_t rs2;
        // register file values read in decode
        isa_pkg::word_t    rs1_val;
        isa_pkg::word_t    rs2_val;
        // I or U immediate, already extended
        isa_pkg::word_t    imm;
        // b comes from imm instead of rs2
        logic              use_imm;
        isa_pkg::alu_op_e  alu_op;
        logic              reg_write;
    } id_ex_t;

    // EX/WB record
    // also the register file write port
    typedef struct packed {
        logic              valid;
        isa_pkg::reg_idx_t rd;
        isa_pkg::word_t    result;
        logic              reg_write;
    } wb_t;

endpackage

`default_nettype wire

//--- hdl/reg_file.sv
//********************
// integer register file, 2 read ports and 1 write port
// write port is the EX/WB record, reads see a pending write
//********************
`timescale 1ns/100ps
`default_nettype none

`include "core_config.svh"

module reg_file (
    input  logic              clk,
    input  logic              reset_n,
    input  isa_pkg::reg_idx_t rs1_addr,
    input  isa_pkg::reg_idx_t rs2_addr,
    input  pipe_pkg::wb_t     wb,
    output isa_pkg::word_t    rs1_data,
    output isa_pkg::word_t    rs2_data
);

    // x0 has no storage
    isa_pkg::word_t regs [1:`CORE_NUM_REGS-1];
    logic           wr_en;

    // writes to x0 are dropped here
    assign wr_en = wb.valid && wb.reg_write && (wb.rd != '0);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 1; i < `CORE_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.rd] <= wb.result;
        end
    end

    // one read port, x0 first, then the write that lands next edge
    function automatic isa_pkg::word_t read_port(isa_pkg::reg_idx_t addr);
        if (addr == '0) begin
            return '0;
        end else if (wr_en && (addr == wb.rd)) begin
            return wb.result;
        end
        return regs[addr];
    endfunction

    assign rs1_data = read_port(rs1_addr);
    assign rs2_data = read_port(rs2_addr);

    // x0 reads zero on both ports, bypass included
    a_x0_zero: assert property (@(posedge clk) disable iff (!reset_n)
        ((rs1_addr == '0) -> (rs1_data == '0)) && ((rs2_addr == '0) -> (rs2_data == '0)));

endmodule

`default_nettype wire

//--- decode/decode_stage.sv
//********************
// decode stage, splits the word and reads the register file
// registers the ID/EX record, or a bubble under stall
//********************
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              instr_valid,
    input  isa_pkg::word_t    instr,
    input  logic              stall,
    input  isa_pkg::word_t    rs1_data,
    input  isa_pkg::word_t    rs2_data,
    output isa_pkg::reg_idx_t rs1_addr,
    output isa_pkg::reg_idx_t rs2_addr,
    output pipe_pkg::id_ex_t  id_ex,
    output logic              illegal
);

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    isa_pkg::word_t   i_imm;
    isa_pkg::word_t   u_imm;
    logic             accept;
    logic             legal;
    logic             use_imm;
    isa_pkg::word_t   imm;
    isa_pkg::alu_op_e alu_op;
    pipe_pkg::id_ex_t id_ex_next;

    // funct3 to alu op, alt picks sub or sra
    function automatic isa_pkg::alu_op_e op_of(logic [2:0] f3, logic alt);
        case (f3)
            isa_pkg::F3_ADD_SUB: return alt ? isa_pkg::ALU_SUB : isa_pkg::ALU_ADD;
            isa_pkg::F3_SLL:     return isa_pkg::ALU_SLL;
            isa_pkg::F3_SLT:     return isa_pkg::ALU_SLT;
            isa_pkg::F3_SLTU:    return isa_pkg::ALU_SLTU;
            isa_pkg::F3_XOR:     return isa_pkg::ALU_XOR;
            isa_pkg::F3_SRL_SRA: return alt ? isa_pkg::ALU_SRA : isa_pkg::ALU_SRL;
            isa_pkg::F3_OR:      return isa_pkg::ALU_OR;
            default:             return isa_pkg::ALU_AND;
        endcase
    endfunction

    // fixed field positions
    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    // sign-extended I immediate, U immediate in the upper bits
    assign i_imm = {{20{instr[31]}}, instr[31:20]};
    assign u_imm = {instr[31:12], 12'b0};

    // stall drops the word, source holds it for later
    assign accept = instr_valid && !stall;

    always_comb begin
        legal   = 1'b1;
        use_imm = 1'b0;
        imm     = i_imm;
        alu_op  = isa_pkg::ALU_ADD;
        case (opcode)
            isa_pkg::OP: begin
                // only sub and sra take the alt funct7
                legal = (funct7 == isa_pkg::F7_BASE) ||
                        ((funct7 == isa_pkg::F7_ALT) &&
                         ((funct3 == isa_pkg::F3_ADD_SUB) || (funct3 == isa_pkg::F3_SRL_SRA)));
                alu_op = op_of(funct3, funct7 == isa_pkg::F7_ALT);
            end
            isa_pkg::OP_IMM: begin
                use_imm = 1'b1;
                // upper imm bits are funct7 for shifts only
                if (funct3 == isa_pkg::F3_SLL) begin
                    legal = (funct7 == isa_pkg::F7_BASE);
                end else if (funct3 == isa_pkg::F3_SRL_SRA) begin
                    legal = (funct7 == isa_pkg::F7_BASE) || (funct7 == isa_pkg::F7_ALT);
                end
                alu_op = op_of(funct3,
                               (funct3 == isa_pkg::F3_SRL_SRA) && (funct7 == isa_pkg::F7_ALT));
            end
            isa_pkg::LUI: begin
                use_imm = 1'b1;
                imm     = u_imm;
                alu_op  = isa_pkg::ALU_PASS_B;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    // bubble unless an accepted legal word
    always_comb begin
        id_ex_next = '0;
        if (accept && legal) begin
            id_ex_next.valid     = 1'b1;
            id_ex_next.rd        = instr[11:7];
            id_ex_next.rs1       = rs1_addr;
            id_ex_next.rs2       = rs2_addr;
            id_ex_next.rs1_val   = rs1_data;
            id_ex_next.rs2_val   = rs2_data;
            id_ex_next.imm       = imm;
            id_ex_next.use_imm   = use_imm;
            id_ex_next.alu_op    = alu_op;
            // every supported op writes rd, x0 filtered in the register file
            id_ex_next.reg_write = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            id_ex   <= '0;
            illegal <= 1'b0;
        end else begin
            id_ex   <= id_ex_next;
            illegal <= accept && !legal;
        end
    end

    // an illegal word never enters ID/EX
    a_no_valid_illegal: assert property (@(posedge clk) disable iff (!reset_n)
        !(id_ex.valid && illegal));

endmodule

`default_nettype wire

//--- execute/alu.sv
//********************
// integer alu for the RV32I register and immediate ops
// purely combinational
//********************
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  isa_pkg::word_t   a,
    input  isa_pkg::word_t   b,
    input  isa_pkg::alu_op_e op,
    output isa_pkg::word_t   result
);

    isa_pkg::shamt_t shamt;

    // only the low bits of b count for shifts
    assign shamt = b[$bits(isa_pkg::shamt_t)-1:0];

    always_comb begin
        case (op)
            isa_pkg::ALU_ADD: begin
                result = a + b;
            end
            isa_pkg::ALU_SUB: begin
                // wraps modulo 2^32
                result = a - b;
            end
            isa_pkg::ALU_SLL: begin
                result = a << shamt;
            end
            isa_pkg::ALU_SLT: begin
                result = ($signed(a) < $signed(b)) ? isa_pkg::word_t'(1) : '0;
            end
            isa_pkg::ALU_SLTU: begin
                result = (a < b) ? isa_pkg::word_t'(1) : '0;
            end
            isa_pkg::ALU_XOR: begin
                result = a ^ b;
            end
            isa_pkg::ALU_SRL: begin
                result = a >> shamt;
            end
            isa_pkg::ALU_SRA: begin
                // sign bit fills from the left
                result = isa_pkg::word_t'($signed(a) >>> shamt);
            end
            isa_pkg::ALU_OR: begin
                result = a | b;
            end
            isa_pkg::ALU_AND: begin
                result = a & b;
            end
            default: begin
                // lui
                result = b;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- execute/execute_stage.sv
//********************
// execute stage, forwards from EX/WB and runs the alu
// registered wb is the pipeline result and the regfile write
//********************
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
    input  logic             clk,
    input  logic             reset_n,
    input  pipe_pkg::id_ex_t id_ex,
    output pipe_pkg::wb_t    wb
);

    logic           wb_live;
    logic           fwd_rs1;
    logic           fwd_rs2;
    isa_pkg::word_t op_a;
    isa_pkg::word_t rs2_val;
    isa_pkg::word_t op_b;
    isa_pkg::word_t alu_result;
    pipe_pkg::wb_t  wb_next;

    // EX/WB holds a write the regfile has not seen yet
    assign wb_live = wb.valid && wb.reg_write && (wb.rd != '0);

    // one-ahead dependency, EX/WB beats the decode-time value
    assign fwd_rs1 = wb_live && (wb.rd == id_ex.rs1);
    assign fwd_rs2 = wb_live && (wb.rd == id_ex.rs2);

    assign op_a    = fwd_rs1 ? wb.result : id_ex.rs1_val;
    assign rs2_val = fwd_rs2 ? wb.result : id_ex.rs2_val;

    // I and U types take the immediate
    assign op_b = id_ex.use_imm ? id_ex.imm : rs2_val;

    alu alu_i (
        .a      (op_a),
        .b      (op_b),
        .op     (id_ex.alu_op),
        .result (alu_result)
    );

    // bubble in, bubble out
    always_comb begin
        wb_next = '0;
        if (id_ex.valid) begin
            wb_next.valid     = 1'b1;
            wb_next.rd        = id_ex.rd;
            wb_next.result    = alu_result;
            wb_next.reg_write = id_ex.reg_write;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wb <= '0;
        end else begin
            wb <= wb_next;
        end
    end

    // a write leaving EX/WB came from a real ID/EX slot one cycle earlier
    a_wb_from_id_ex: assert property (@(posedge clk) disable iff (!reset_n)
        (wb.valid && wb.reg_write) |-> $past(id_ex.valid));

endmodule

`default_nettype wire

//--- hdl/rv_core_top.sv
//********************
// RV32I integer pipeline, decode then execute
// words in on instr_valid, results out on wb two cycles on
//********************
`timescale 1ns/100ps
`default_nettype none

module rv_core_top (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           instr_valid,
    input  isa_pkg::word_t instr,
    input  logic           stall,
    output pipe_pkg::wb_t  wb,
    output logic           illegal
);

    // decode to register file
    isa_pkg::reg_idx_t rs1_addr;
    isa_pkg::reg_idx_t rs2_addr;
    isa_pkg::word_t    rs1_data;
    isa_pkg::word_t    rs2_data;

    // decode to execute
    pipe_pkg::id_ex_t  id_ex;

    decode_stage decode_stage_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .stall       (stall),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .id_ex       (id_ex),
        .illegal     (illegal)
    );

    // wb also goes out as the top-level result
    execute_stage execute_stage_i (
        .clk     (clk),
        .reset_n (reset_n),
        .id_ex   (id_ex),
        .wb      (wb)
    );

    // EX/WB drives the write port directly
    reg_file reg_file_i (
        .clk      (clk),
        .reset_n  (reset_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

endmodule

`default_nettype wire

//--- bench/tb_rv_core.sv
//********************
// testbench for the RV32I decode/execute pipeline
// directed words first, then LFSR words with stall and gaps
//********************
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core;

    localparam int CLK_PERIOD      = 4;
    localparam int NUM_DIRECTED    = 14;
    localparam int NUM_RANDOM      = 500;
    localparam int NUM_INSTR       = NUM_DIRECTED + NUM_RANDOM;
    localparam int WATCHDOG_CYCLES = NUM_INSTR * 4 + 100;

    logic           clk;
    logic           reset_n;
    logic           instr_valid;
    isa_pkg::word_t instr;
    logic           stall;
    pipe_pkg::wb_t  wb;
    logic           illegal;

    // posedges since time zero
    int             cycle;
    logic           checking;
    logic [31:0]    lfsr_state;
    // in-order architectural state
    isa_pkg::word_t model_regs [0:31];

    // expectations stamped with the cycle they are due
    int             wb_due_q [$];
    pipe_pkg::wb_t  wb_exp_q [$];
    int             ill_due_q [$];

    rv_core_top rv_core_top_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .stall       (stall),
        .wb          (wb),
        .illegal     (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // RV32I encoders
    function automatic isa_pkg::word_t enc_r(input logic [6:0] f7, input isa_pkg::reg_idx_t rs2,
                                             input isa_pkg::reg_idx_t rs1, input logic [2:0] f3,
                                             input isa_pkg::reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic isa_pkg::word_t enc_i(input logic [11:0] imm, input isa_pkg::reg_idx_t rs1,
                                             input logic [2:0] f3, input isa_pkg::reg_idx_t rd);
        return {imm, rs1, f3, rd, 7'h13};
    endfunction

    function automatic isa_pkg::word_t enc_u(input logic [19:0] imm, input isa_pkg::reg_idx_t rd);
        return {imm, rd, 7'h37};
    endfunction

    // executes one accepted word on the model, flags words outside the subset
    function automatic pipe_pkg::wb_t ref_exec(input isa_pkg::word_t w, output logic bad);
        logic [6:0]        opc;
        logic [6:0]        f7;
        logic [2:0]        f3;
        isa_pkg::reg_idx_t rd;
        isa_pkg::word_t    a;
        isa_pkg::word_t    b;
        isa_pkg::word_t    r;
        logic              alt;
        pipe_pkg::wb_t     res;
        opc = w[6:0];
        f3  = w[14:12];
        f7  = w[31:25];
        rd  = w[11:7];
        a   = model_regs[w[19:15]];
        b   = '0;
        r   = '0;
        alt = 1'b0;
        bad = 1'b0;
        res = '0;
        case (opc)
            7'h33: begin
                b   = model_regs[w[24:20]];
                alt = (f7 == 7'h20);
                bad = !((f7 == 7'h00) || (alt && ((f3 == 3'd0) || (f3 == 3'd5))));
            end
            7'h13: begin
                b   = {{20{w[31]}}, w[31:20]};
                // only srai uses the alt encoding, addi has no subi
                alt = (f3 == 3'd5) && (f7 == 7'h20);
                bad = ((f3 == 3'd1) && (f7 != 7'h00)) ||
                      ((f3 == 3'd5) && (f7 != 7'h00) && (f7 != 7'h20));
            end
            7'h37: begin
                b = {w[31:12], 12'h000};
            end
            default: begin
                bad = 1'b1;
            end
        endcase
        if (opc == 7'h37) begin
            r = b;
        end else begin
            case (f3)
                3'd0: r = alt ? a - b : a + b;
                3'd1: r = a << b[4:0];
                3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'd3: r = (a < b) ? 32'd1 : 32'd0;
                3'd4: r = a ^ b;
                3'd5: begin
                    // arithmetic shift kept out of a ternary, else it goes unsigned
                    if (alt) begin
                        r = $signed(a) >>> b[4:0];
                    end else begin
                        r = a >> b[4:0];
                    end
                end
                3'd6: r = a | b;
                default: r = a & b;
            endcase
        end
        if (!bad) begin
            res.valid     = 1'b1;
            res.rd        = rd;
            res.result    = r;
            res.reg_write = 1'b1;
            // x0 stays zero in the model
            if (rd != '0) begin
                model_regs[rd] = r;
            end
        end
        return res;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_wb(input pipe_pkg::wb_t exp);
        if (wb.valid !== exp.valid) begin
            stop_on_error($sformatf("ERR wb.valid expected %h got %h", exp.valid, wb.valid));
        end else if (exp.valid && (wb.rd !== exp.rd)) begin
            stop_on_error($sformatf("ERR wb.rd expected %h got %h", exp.rd, wb.rd));
        end else if (exp.valid && (wb.result !== exp.result)) begin
            stop_on_error($sformatf("ERR wb.result expected %h got %h", exp.result, wb.result));
        end else if (exp.valid && (wb.reg_write !== exp.reg_write)) begin
            stop_on_error($sformatf("ERR wb.reg_write expected %h got %h",
                                    exp.reg_write, wb.reg_write));
        end
    endtask

    task automatic check_illegal(input logic exp);
        if (illegal !== exp) begin
            stop_on_error($sformatf("ERR illegal expected %h got %h", exp, illegal));
        end
    endtask

    // outputs are registered, stable at the falling edge
    always @(negedge clk) begin
        if (checking) begin
            if ((wb_due_q.size() > 0) && (wb_due_q[0] == cycle)) begin
                check_wb(wb_exp_q[0]);
                void'(wb_due_q.pop_front());
                void'(wb_exp_q.pop_front());
            end else begin
                check_wb('0);
            end
            if ((ill_due_q.size() > 0) && (ill_due_q[0] == cycle)) begin
                check_illegal(1'b1);
                void'(ill_due_q.pop_front());
            end else begin
                check_illegal(1'b0);
            end
        end
    end

    // holds the word under stall until it is taken once
    task automatic issue(input isa_pkg::word_t w, input logic allow_stall);
        logic [31:0]   r;
        pipe_pkg::wb_t exp;
        logic          bad;
        logic          taken;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            rand_bits(2, r);
            instr_valid = 1'b1;
            instr       = w;
            stall       = allow_stall && (r[1:0] == 2'd0);
            if (!stall) begin
                exp = ref_exec(w, bad);
                // sampled at edge cycle+1, illegal shows right after it, wb one edge later
                if (bad) begin
                    ill_due_q.push_back(cycle + 1);
                end else begin
                    wb_due_q.push_back(cycle + 2);
                    wb_exp_q.push_back(exp);
                end
                taken = 1'b1;
            end
        end
    endtask

    task automatic idle_cycle(input logic allow_stall);
        logic [31:0] r;
        @(negedge clk);
        rand_bits(1, r);
        instr_valid = 1'b0;
        stall       = allow_stall && r[0];
    endtask

    // registers x0..x7 only, so hazards come often
    task automatic make_random(output isa_pkg::word_t w);
        logic [31:0] kind;
        logic [31:0] f3;
        logic [31:0] alt;
        logic [31:0] rd;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] imm;
        rand_bits(3, kind);
        rand_bits(3, f3);
        rand_bits(1, alt);
        rand_bits(3, rd);
        rand_bits(3, rs1);
        rand_bits(3, rs2);
        rand_bits(20, imm);
        case (kind[2:0])
            3'd0, 3'd1, 3'd2: begin
                w = enc_r((alt[0] && ((f3[2:0] == 3'd0) || (f3[2:0] == 3'd5))) ? 7'h20 : 7'h00,
                          rs2[4:0], rs1[4:0], f3[2:0], rd[4:0]);
            end
            3'd3, 3'd4, 3'd5: begin
                if (f3[2:0] == 3'd1) begin
                    imm[11:5] = 7'h00;
                end else if (f3[2:0] == 3'd5) begin
                    imm[11:5] = alt[0] ? 7'h20 : 7'h00;
                end
                w = enc_i(imm[11:0], rs1[4:0], f3[2:0], rd[4:0]);
            end
            3'd6: begin
                w = enc_u(imm[19:0], rd[4:0]);
            end
            default: begin
                // mostly illegal: any word, or an M-extension funct7
                if (alt[0]) begin
                    rand_bits(32, w);
                end else begin
                    w = enc_r(7'h01, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0]);
                end
            end
        endcase
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_on_error("watchdog timeout, the test did not finish in time");
    end

    initial begin
        isa_pkg::word_t w;
        logic [31:0]    gap;
        reset_n     = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        stall       = 1'b0;
        cycle       = 0;
        checking    = 1'b0;
        lfsr_state  = 32'd22;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (10) @(negedge clk);
        reset_n  = 1'b1;
        checking = 1'b1;
        // quiet outputs after reset
        repeat (8) idle_cycle(1'b0);
        issue(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd1), 1'b0);
        issue(enc_u(20'h80000, 5'd2), 1'b0);
        issue(enc_i(12'd1, 5'd0, 3'd0, 5'd3), 1'b0);
        // sub wraps, x3 forwarded from EX/WB
        issue(enc_r(7'h20, 5'd3, 5'd0, 3'd0, 5'd4), 1'b0);
        // srai and sra fill with the sign
        issue(enc_i(12'h404, 5'd2, 3'd5, 5'd5), 1'b0);
        issue(enc_r(7'h20, 5'd3, 5'd2, 3'd5, 5'd6), 1'b0);
        // slt sees -1 < 1, sltu does not
        issue(enc_r(7'h00, 5'd3, 5'd4, 3'd2, 5'd7), 1'b0);
        issue(enc_r(7'h00, 5'd3, 5'd4, 3'd3, 5'd7), 1'b0);
        // write to x0, then read x0 back
        issue(enc_i(12'd5, 5'd3, 3'd0, 5'd0), 1'b0);
        issue(enc_r(7'h00, 5'd0, 5'd3, 3'd0, 5'd1), 1'b0);
        // ecall, mul and slli with funct7 0x20
        issue(32'h0000_0073, 1'b0);
        issue(enc_r(7'h01, 5'd3, 5'd4, 3'd0, 5'd1), 1'b0);
        issue(enc_i(12'h401, 5'd3, 3'd1, 5'd2), 1'b0);
        // x1 untouched by the illegal words
        issue(enc_r(7'h00, 5'd0, 5'd1, 3'd0, 5'd2), 1'b0);
        for (int n = 0; n < NUM_RANDOM; n++) begin
            rand_bits(2, gap);
            if (gap[1:0] == 2'd0) begin
                idle_cycle(1'b1);
            end
            make_random(w);
            issue(w, 1'b1);
        end
        // pipeline depth is fixed, a few cycles drain it
        repeat (6) idle_cycle(1'b0);
        if ((wb_due_q.size() != 0) || (ill_due_q.size() != 0)) begin
            stop_on_error("some expected results never appeared on the outputs");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+common
common/isa_pkg.sv
common/pipe_pkg.sv
hdl/reg_file.sv
decode/decode_stage.sv
execute/alu.sv
execute/execute_stage.sv
hdl/rv_core_top.sv
bench/tb_rv_core.sv

//--- run_sim.sh
#!/bin/sh
# builds the RV32I pipeline testbench with Verilator and runs it
# a nonzero exit status means the build or the simulation failed

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_rv_core \
    -f project.f \
    -Mdir obj_dir \
    -o sim_rv_core
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit $status
fi

./obj_dir/sim_rv_core
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
